// File: tx_stream_pkg.sv
// Shared widths, IQ and control structs, command opcodes for the TX ingest path
// Opcode values are the 6-bit address field of the host command word

package tx_stream_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int NIBBLE_W   = 4;
  localparam int BYTE_W     = 8;
  localparam int WORD_W     = 32;
  localparam int RATE_DIV_W = 10;

  // One IQ sample pair as it leaves the FIFO
  // i_sample sits in the upper half of the byte-reversed word
  typedef struct packed {
    logic [WORD_W/2-1:0] i_sample;
    logic [WORD_W/2-1:0] q_sample;
  } iq_word_t;

  // Transmit control state
  typedef struct packed {
    logic                  run;
    logic                  ptt;
    logic                  cwx_en;
    // Tick period in clocks, minus one
    logic [RATE_DIV_W-1:0] rate_div;
  } tx_ctrl_t;

  // Reset value: idle, receive, 8-clock sample period
  localparam tx_ctrl_t TX_CTRL_RST = '{run: 1'b0, ptt: 1'b0, cwx_en: 1'b0,
                                       rate_div: RATE_DIV_W'(7)};

  // --------------------------------------------------
  // Command interface
  // --------------------------------------------------
  typedef enum logic [5:0] {
    OP_NOP         = 6'h00,
    OP_TX_CTRL     = 6'h01,  // data[2:0] = {cwx_en, ptt, run}
    OP_SAMPLE_RATE = 6'h02   // data[9:0] = rate_div
  } tx_opcode_e;

  // Low 38 bits of the 48-bit host command
  typedef struct packed {
    tx_opcode_e  opcode;
    logic [31:0] data;
  } tx_cmd_t;

endpackage

// File: tx_nibble_assembler.sv
// Joins two nibbles into a byte, high nibble first, both on rising edges
// A frame-start nibble always opens a new byte; a half byte in progress is lost
`timescale 1ns/10ps

module tx_nibble_assembler import tx_stream_pkg::*; (
  input  logic                pi_tx_clk,
  input  logic                rst,
  input  logic [NIBBLE_W-1:0] pi_tx_data,
  input  logic                tx_nibble_valid,
  input  logic                tx_frame_start,
  output logic [BYTE_W-1:0]   byte_data,
  output logic                byte_strobe,
  output logic                frame_restart
);

  // Set while the next nibble is the low half
  logic                low_phase;
  logic [NIBBLE_W-1:0] hi_nibble;
  logic                take_high;

  // A nibble goes to the high half on frame start or when no byte is open
  assign take_high = tx_frame_start || !low_phase;

  // --------------------------------------------------
  // Phase and strobes
  // --------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (rst) begin
      low_phase     <= 1'b0;
      byte_strobe   <= 1'b0;
      frame_restart <= 1'b0;
    end else begin
      // Single-cycle pulses by default
      byte_strobe   <= 1'b0;
      frame_restart <= 1'b0;
      if (tx_nibble_valid) begin
        if (take_high) begin
          low_phase <= 1'b1;
        end else begin
          low_phase   <= 1'b0;
          byte_strobe <= 1'b1;
        end
        // Tells the packer to restart at byte 0
        frame_restart <= tx_frame_start;
      end
    end
  end

  // --------------------------------------------------
  // Nibble data
  // --------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (tx_nibble_valid) begin
      if (take_high) begin
        hi_nibble <= pi_tx_data;
      end else begin
        byte_data <= {hi_nibble, pi_tx_data};
      end
    end
  end

endmodule

// File: iq_word_packer.sv
// Packs bytes b0..b3 into the word {b3, b2, b1, b0}
// frame_restart never coincides with byte_strobe from the assembler
`timescale 1ns/10ps

module iq_word_packer import tx_stream_pkg::*; (
  input  logic              pi_tx_clk,
  input  logic              rst,
  input  logic [BYTE_W-1:0] byte_data,
  input  logic              byte_strobe,
  input  logic              frame_restart,
  output iq_word_t          word,
  output logic              word_strobe
);

  // Position of the next byte within the word
  logic [1:0]        byte_cnt;
  // Bytes enter at the top and move down, so b0 ends in the lowest lane
  logic [WORD_W-1:0] shift_q;

  // --------------------------------------------------
  // Byte count and word strobe
  // --------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (rst) begin
      byte_cnt    <= 2'd0;
      word_strobe <= 1'b0;
    end else begin
      word_strobe <= 1'b0;
      if (frame_restart) begin
        // Realign to byte 0
        byte_cnt <= 2'd0;
      end else if (byte_strobe) begin
        // Wraps from 3 back to 0 on its own
        byte_cnt <= byte_cnt + 2'd1;
        if (byte_cnt == 2'd3) begin
          word_strobe <= 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // Byte shift register
  // --------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (byte_strobe && !frame_restart) begin
      shift_q <= {byte_data, shift_q[WORD_W-1:BYTE_W]};
    end
  end

  // After the fourth shift the register holds the full reversed word,
  // stable while word_strobe is high
  assign word = iq_word_t'(shift_q);

endmodule

// File: dsiq_fifo.sv
// Show-ahead register FIFO, FIFO_DEPTH a power of two and at least 2
// Writes to a full FIFO are dropped; overflow stays set until reset
`timescale 1ns/10ps

module dsiq_fifo import tx_stream_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                        pi_tx_clk,
  input  logic                        rst,
  input  iq_word_t                    wr_word,
  input  logic                        wr_strobe,
  input  logic                        rd_pop,
  input  logic                        flush,
  output iq_word_t                    rd_word,
  output logic                        empty,
  output logic [$clog2(FIFO_DEPTH):0] level,
  output logic                        overflow
);

  localparam int AW = $clog2(FIFO_DEPTH);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------
  iq_word_t      mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          wr_ok;
  logic          rd_ok;

  assign full  = (level == (AW+1)'(FIFO_DEPTH));
  assign empty = (level == '0);

  // Accepted write and read this cycle
  assign wr_ok = wr_strobe && !full && !flush;
  assign rd_ok = rd_pop && !empty && !flush;

  // Head word shown before the pop
  assign rd_word = mem[rd_ptr];

  always_ff @(posedge pi_tx_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // --------------------------------------------------
  // Pointer and level update
  // --------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else if (flush) begin
      // Drop everything, flags untouched
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      // Pointers wrap by width
      if (wr_ok) begin
        wr_ptr <= wr_ptr + AW'(1);
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      case ({wr_ok, rd_ok})
        2'b10:   level <= level + (AW+1)'(1);
        2'b01:   level <= level - (AW+1)'(1);
        default: level <= level;
      endcase
    end
  end

  // --------------------------------------------------
  // Sticky overflow
  // --------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (rst) begin
      overflow <= 1'b0;
    end else if (wr_strobe && full) begin
      overflow <= 1'b1;
    end
  end

endmodule

// File: tx_control_regs.sv
// Command decoder for the transmit control state
// Unknown opcodes are ignored; only the addressed fields change
`timescale 1ns/10ps

module tx_control_regs import tx_stream_pkg::*; (
  input  logic     pi_tx_clk,
  input  logic     rst,
  input  tx_cmd_t  cmd,
  input  logic     cmd_strobe,
  output tx_ctrl_t tx_ctrl
);

  // --------------------------------------------------
  // Opcode decode
  // --------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (rst) begin
      tx_ctrl <= TX_CTRL_RST;
    end else if (cmd_strobe) begin
      case (cmd.opcode)
        OP_TX_CTRL: begin
          // Run, PTT and CW-by-IQ enable in one write
          tx_ctrl.run    <= cmd.data[0];
          tx_ctrl.ptt    <= cmd.data[1];
          tx_ctrl.cwx_en <= cmd.data[2];
        end
        OP_SAMPLE_RATE: begin
          tx_ctrl.rate_div <= cmd.data[RATE_DIV_W-1:0];
        end
        OP_NOP: begin
          tx_ctrl <= tx_ctrl;
        end
        default: begin
          // Unassigned address, state kept
          tx_ctrl <= tx_ctrl;
        end
      endcase
    end
  end

endmodule

// File: tx_sample_sender.sv
// Releases one FIFO word per sample tick, zeroed while PTT is clear
// Flush is a one-cycle pulse when run falls; words written with run clear are kept
`timescale 1ns/10ps

module tx_sample_sender import tx_stream_pkg::*; (
  input  logic     pi_tx_clk,
  input  logic     rst,
  input  tx_ctrl_t tx_ctrl,
  input  iq_word_t head_word,
  input  logic     empty,
  output logic     pop,
  output logic     flush,
  output iq_word_t dac_word,
  output logic     dac_strobe,
  output logic     cw_key,
  output logic     tx_on,
  output logic     underrun
);

  logic [RATE_DIV_W-1:0] tick_cnt;
  logic                  tick;
  logic                  run_q;

  // --------------------------------------------------
  // Sample tick
  // --------------------------------------------------
  assign tick = tx_ctrl.run && (tick_cnt == '0);

  always_ff @(posedge pi_tx_clk) begin
    if (rst) begin
      tick_cnt <= TX_CTRL_RST.rate_div;
    end else if (!tx_ctrl.run || tick_cnt == '0) begin
      // Held at the period while stopped, restarted after each tick
      tick_cnt <= tx_ctrl.rate_div;
    end else begin
      tick_cnt <= tick_cnt - RATE_DIV_W'(1);
    end
  end

  // Run edge detect for the flush pulse
  always_ff @(posedge pi_tx_clk) begin
    if (rst) begin
      run_q <= 1'b0;
    end else begin
      run_q <= tx_ctrl.run;
    end
  end

  assign flush = run_q && !tx_ctrl.run;
  assign pop   = tick && !empty;

  // --------------------------------------------------
  // DAC side outputs
  // --------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (rst) begin
      dac_strobe <= 1'b0;
      cw_key     <= 1'b0;
      tx_on      <= 1'b0;
      underrun   <= 1'b0;
    end else begin
      dac_strobe <= pop;
      tx_on      <= tx_ctrl.run && tx_ctrl.ptt;
      // Key-down follows the word just sent; key-up while stopped
      if (pop) begin
        cw_key <= tx_ctrl.cwx_en && tx_ctrl.ptt && (|head_word);
      end else if (!tx_ctrl.run) begin
        cw_key <= 1'b0;
      end
      // Tick with nothing queued
      if (tick && empty) begin
        underrun <= 1'b1;
      end
    end
  end

  // Sample payload, zero unless PTT is on
  always_ff @(posedge pi_tx_clk) begin
    if (pop) begin
      dac_word <= tx_ctrl.ptt ? head_word : '0;
    end
  end

endmodule

// File: tx_iq_top.sv
// Transmit IQ ingest top: nibbles in, paced IQ words out, single clock
// Command word bits 47:38 are not decoded
`timescale 1ns/10ps

module tx_iq_top import tx_stream_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                        pi_tx_clk,
  input  logic                        rst,
  input  logic [NIBBLE_W-1:0]         pi_tx_data,
  input  logic                        tx_nibble_valid,
  input  logic                        tx_frame_start,
  input  logic [47:0]                 cmd_word,
  input  logic                        cmd_strobe,
  output iq_word_t                    dac_word,
  output logic                        dac_strobe,
  output logic                        cw_key,
  output logic                        tx_on,
  output logic [$clog2(FIFO_DEPTH):0] fifo_level,
  output logic                        overflow,
  output logic                        underrun
);

  // --------------------------------------------------
  // Internal links
  // --------------------------------------------------
  logic [BYTE_W-1:0] byte_data;
  logic              byte_strobe;
  logic              frame_restart;
  iq_word_t          word;
  logic              word_strobe;
  iq_word_t          head_word;
  logic              fifo_empty;
  logic              pop;
  logic              flush;
  tx_cmd_t           cmd;
  tx_ctrl_t          tx_ctrl;

  // Opcode and data from the low 38 bits
  assign cmd = tx_cmd_t'(cmd_word[37:0]);

  tx_nibble_assembler u_assembler (
    .pi_tx_clk       (pi_tx_clk),
    .rst             (rst),
    .pi_tx_data      (pi_tx_data),
    .tx_nibble_valid (tx_nibble_valid),
    .tx_frame_start  (tx_frame_start),
    .byte_data       (byte_data),
    .byte_strobe     (byte_strobe),
    .frame_restart   (frame_restart)
  );

  iq_word_packer u_packer (
    .pi_tx_clk     (pi_tx_clk),
    .rst           (rst),
    .byte_data     (byte_data),
    .byte_strobe   (byte_strobe),
    .frame_restart (frame_restart),
    .word          (word),
    .word_strobe   (word_strobe)
  );

  dsiq_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .pi_tx_clk (pi_tx_clk),
    .rst       (rst),
    .wr_word   (word),
    .wr_strobe (word_strobe),
    .rd_pop    (pop),
    .flush     (flush),
    .rd_word   (head_word),
    .empty     (fifo_empty),
    .level     (fifo_level),
    .overflow  (overflow)
  );

  tx_control_regs u_ctrl (
    .pi_tx_clk  (pi_tx_clk),
    .rst        (rst),
    .cmd        (cmd),
    .cmd_strobe (cmd_strobe),
    .tx_ctrl    (tx_ctrl)
  );

  tx_sample_sender u_sender (
    .pi_tx_clk  (pi_tx_clk),
    .rst        (rst),
    .tx_ctrl    (tx_ctrl),
    .head_word  (head_word),
    .empty      (fifo_empty),
    .pop        (pop),
    .flush      (flush),
    .dac_word   (dac_word),
    .dac_strobe (dac_strobe),
    .cw_key     (cw_key),
    .tx_on      (tx_on),
    .underrun   (underrun)
  );

endmodule

// File: tx_iq_assertions.sv
// Concurrent checks on tx_iq_top attached by bind
// Flag rules are checked only outside reset
`timescale 1ns/10ps

module tx_iq_assertions_chk (
  input logic pi_tx_clk,
  input logic rst,
  input logic run,
  input logic dac_strobe,
  input logic overflow,
  input logic underrun
);

  int pulse_fails = 0;
  int ovf_fails   = 0;
  int und_fails   = 0;
  int run_fails   = 0;
  int fail_cnt;

  // Number of failed checks so far
  assign fail_cnt = pulse_fails + ovf_fails + und_fails + run_fails;

  // --------------------------------------------------
  // Handshake and sticky flags
  // --------------------------------------------------
  a_strobe_pulse: assert property (@(posedge pi_tx_clk) disable iff (rst)
    dac_strobe |=> !dac_strobe)
    else begin
      $error("dac_strobe high for more than one cycle");
      pulse_fails++;
    end

  a_ovf_sticky: assert property (@(posedge pi_tx_clk) disable iff (rst)
    $past(overflow) |-> overflow)
    else begin
      $error("overflow cleared without reset");
      ovf_fails++;
    end

  a_und_sticky: assert property (@(posedge pi_tx_clk) disable iff (rst)
    $past(underrun) |-> underrun)
    else begin
      $error("underrun cleared without reset");
      und_fails++;
    end

  // No sample leaves while transmit is stopped
  a_strobe_run: assert property (@(posedge pi_tx_clk) disable iff (rst)
    dac_strobe |-> run)
    else begin
      $error("dac_strobe while run was clear");
      run_fails++;
    end

endmodule

bind tx_iq_top tx_iq_assertions_chk chk0 (
  .pi_tx_clk  (pi_tx_clk),
  .rst        (rst),
  .run        (tx_ctrl.run),
  .dac_strobe (dac_strobe),
  .overflow   (overflow),
  .underrun   (underrun)
);

// File: tb_tx_iq.sv
// Table-driven testbench for tx_iq_top, DUT reset before every row
// Expected DAC words come from a byte-reversal, PTT and CW model of the sent bytes
`timescale 1ns/10ps

module tb_tx_iq import tx_stream_pkg::*; ();

  localparam int FIFO_DEPTH = 16;
  localparam int N_ROWS     = 6;

  // One scenario
  typedef struct packed {
    logic        ptt;
    logic        cwx_en;
    logic        preload;    // load with run clear, start afterwards
    logic        stray;      // stray nibbles before the first word
    logic [9:0]  rate_div;
    logic [7:0]  n_words;
    logic [31:0] zero_mask;  // bit w set, word w is all zero
    logic        exp_ovf;
    logic        exp_und;
    logic        chk_rate;   // strobe spacing must equal rate_div+1
  } row_t;

  // ptt cwx pre stray rate words zero_mask ovf und rate
  localparam row_t ROWS [N_ROWS] = '{
    '{1'b1, 1'b0, 1'b0, 1'b0, 10'd3, 8'd12, 32'h0000_0000, 1'b0, 1'b1, 1'b0},
    '{1'b0, 1'b1, 1'b0, 1'b0, 10'd5, 8'd6, 32'h0000_0000, 1'b0, 1'b1, 1'b0},
    '{1'b1, 1'b1, 1'b0, 1'b0, 10'd4, 8'd10, 32'h0000_0125, 1'b0, 1'b1, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b1, 10'd3, 8'd6, 32'h0000_0000, 1'b0, 1'b1, 1'b0},
    '{1'b1, 1'b1, 1'b1, 1'b0, 10'd2, 8'(FIFO_DEPTH + 2), 32'h0000_0810, 1'b1, 1'b1, 1'b1},
    '{1'b1, 1'b0, 1'b1, 1'b0, 10'd9, 8'd8, 32'h0000_0000, 1'b0, 1'b1, 1'b1}
  };

  logic                        pi_tx_clk;
  logic                        rst;
  logic [3:0]                  pi_tx_data;
  logic                        tx_nibble_valid;
  logic                        tx_frame_start;
  logic [47:0]                 cmd_word;
  logic                        cmd_strobe;
  iq_word_t                    dac_word;
  logic                        dac_strobe;
  logic                        cw_key;
  logic                        tx_on;
  logic [$clog2(FIFO_DEPTH):0] fifo_level;
  logic                        overflow;
  logic                        underrun;

  // --------------------------------------------------
  // Reference model state
  // --------------------------------------------------
  logic [31:0] exp_q [$];      // byte-reversed words, filled by the stimulus
  int          exp_rd = 0;     // next entry to compare, owned by the monitor
  int          strobe_total = 0;
  int          row_base = 0;   // strobe count at row start
  int          last_cycle = 0;
  int          cycle = 0;
  int          mismatch_cnt = 0;
  int          stray_cnt = 0;
  int          flag_err_cnt = 0;
  logic        cur_ptt = 1'b0;
  logic        cur_cwx = 1'b0;
  logic        cur_chk_rate = 1'b0;
  logic [9:0]  cur_rate = 10'd7;

  tx_iq_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

  initial begin
    pi_tx_clk = 1'b0;
    forever #20 pi_tx_clk = ~pi_tx_clk;
  end

  always @(posedge pi_tx_clk) cycle <= cycle + 1;

  // --------------------------------------------------
  // Stimulus tasks, inputs change on the falling edge
  // --------------------------------------------------
  task automatic apply_reset();
    rst = 1'b1;
    repeat (8) @(negedge pi_tx_clk);
    rst = 1'b0;
  endtask

  task automatic send_cmd(input tx_opcode_e op, input logic [31:0] data);
    @(negedge pi_tx_clk);
    cmd_word   = {10'd0, op, data};
    cmd_strobe = 1'b1;
    @(negedge pi_tx_clk);
    cmd_strobe = 1'b0;
  endtask

  task automatic send_nibble(input logic [3:0] nib, input logic first);
    @(negedge pi_tx_clk);
    pi_tx_data      = nib;
    tx_nibble_valid = 1'b1;
    tx_frame_start  = first;
  endtask

  task automatic end_nibbles();
    @(negedge pi_tx_clk);
    tx_nibble_valid = 1'b0;
    tx_frame_start  = 1'b0;
  endtask

  // Bytes b0..b3, high nibble first; the radio sees {b3, b2, b1, b0}
  task automatic send_word(input logic [3:0][7:0] b, input logic kept);
    if (kept) exp_q.push_back({b[3], b[2], b[1], b[0]});
    for (int k = 0; k < 4; k++) begin
      send_nibble(b[2'(k)][7:4], k == 0);
      send_nibble(b[2'(k)][3:0], 1'b0);
    end
  endtask

  task automatic run_row(input row_t row);
    logic [3:0][7:0] b;
    logic            zero_word;
    int              n_out;
    int              target;
    apply_reset();
    row_base     = strobe_total;
    cur_ptt      = row.ptt;
    cur_cwx      = row.cwx_en;
    cur_rate     = row.rate_div;
    cur_chk_rate = row.chk_rate;
    // Preloaded words beyond the FIFO depth are dropped
    n_out = int'(row.n_words);
    if (row.preload && n_out > FIFO_DEPTH) n_out = FIFO_DEPTH;
    target = strobe_total + n_out;
    send_cmd(OP_SAMPLE_RATE, 32'(row.rate_div));
    send_cmd(OP_TX_CTRL, {29'd0, row.cwx_en, row.ptt, !row.preload});
    if (row.stray) begin
      // One full byte and a half byte that frame start must discard
      repeat (3) send_nibble(4'($urandom), 1'b0);
    end
    for (int w = 0; w < int'(row.n_words); w++) begin
      zero_word = ((row.zero_mask >> w) & 32'h1) != 32'h0;
      for (int k = 0; k < 4; k++) b[2'(k)] = zero_word ? 8'h00 : 8'($urandom);
      send_word(b, !row.preload || w < FIFO_DEPTH);
    end
    end_nibbles();
    if (row.preload) begin
      repeat (4) @(negedge pi_tx_clk);
      assert (int'(fifo_level) == n_out) else begin
        flag_err_cnt++;
        $display("mismatch at %0t: fifo_level %0d, expected %0d", $time, fifo_level, n_out);
      end
      send_cmd(OP_TX_CTRL, {29'd0, row.cwx_en, row.ptt, 1'b1});
    end
    while (strobe_total < target) @(negedge pi_tx_clk);
    // Room for one more tick on an empty FIFO
    repeat (2 * (int'(row.rate_div) + 1) + 2) @(negedge pi_tx_clk);
    assert (strobe_total == target) else begin
      flag_err_cnt++;
      $display("Row produced %0d DAC strobes instead of %0d", strobe_total - row_base, n_out);
    end
    assert (overflow == row.exp_ovf) else begin
      flag_err_cnt++;
      $display("mismatch at %0t: overflow %b, expected %b", $time, overflow, row.exp_ovf);
    end
    assert (underrun == row.exp_und) else begin
      flag_err_cnt++;
      $display("mismatch at %0t: underrun %b, expected %b", $time, underrun, row.exp_und);
    end
  endtask

  // --------------------------------------------------
  // Output monitor, samples between rising edges
  // --------------------------------------------------
  always @(negedge pi_tx_clk) begin : monitor
    logic [31:0] raw;
    logic [31:0] exp_dac;
    logic        exp_key;
    if (!rst && dac_strobe) begin
      assert (exp_rd < exp_q.size()) else begin
        stray_cnt++;
        $display("DAC strobe at %0t with no word left in the model", $time);
      end
      if (exp_rd < exp_q.size()) begin
        raw     = exp_q[exp_rd];
        exp_dac = cur_ptt ? raw : 32'h0;
        exp_key = cur_cwx && cur_ptt && (raw != 32'h0);
        assert (dac_word == exp_dac) else begin
          mismatch_cnt++;
          $display("mismatch at %0t: dac_word %h, expected %h", $time, dac_word, exp_dac);
        end
        assert (cw_key == exp_key) else begin
          mismatch_cnt++;
          $display("mismatch at %0t: cw_key %b, expected %b", $time, cw_key, exp_key);
        end
        assert (tx_on == cur_ptt) else begin
          mismatch_cnt++;
          $display("mismatch at %0t: tx_on %b, expected %b", $time, tx_on, cur_ptt);
        end
        if (cur_chk_rate && strobe_total > row_base) begin
          assert (cycle - last_cycle == int'(cur_rate) + 1) else begin
            mismatch_cnt++;
            $display("mismatch at %0t: strobe spacing %0d, expected %0d", $time,
                     cycle - last_cycle, int'(cur_rate) + 1);
          end
        end
      end
      last_cycle = cycle;
      exp_rd++;
      strobe_total++;
    end
  end

  // Sample periods of all rows, twice over, plus feed and reset time
  function automatic int budget_cycles();
    int total;
    total = 500;
    for (int r = 0; r < N_ROWS; r++) begin
      total += int'(ROWS[3'(r)].n_words) * (int'(ROWS[3'(r)].rate_div) + 1) * 2;
      total += int'(ROWS[3'(r)].n_words) * 10 + 100;
    end
    return total;
  endfunction

  initial begin : watchdog
    int limit;
    limit = budget_cycles();
    repeat (limit) @(posedge pi_tx_clk);
    $display("Timeout after %0d clock cycles, the rows did not complete", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : stimulus
    int total_err;
    rst             = 1'b1;
    pi_tx_data      = 4'h0;
    tx_nibble_valid = 1'b0;
    tx_frame_start  = 1'b0;
    cmd_word        = 48'h0;
    cmd_strobe      = 1'b0;
    void'($urandom(32'hd791));
    apply_reset();
    for (int r = 0; r < N_ROWS; r++) run_row(ROWS[3'(r)]);
    total_err = mismatch_cnt + stray_cnt + flag_err_cnt + dut0.chk0.fail_cnt;
    $display("Errors: %0d mismatch, %0d extra strobe, %0d flag, %0d assertion",
             mismatch_cnt, stray_cnt, flag_err_cnt, dut0.chk0.fail_cnt);
    if (total_err == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
tx_stream_pkg.sv
tx_nibble_assembler.sv
iq_word_packer.sv
dsiq_fifo.sv
tx_control_regs.sv
tx_sample_sender.sv
tx_iq_top.sv
tx_iq_assertions.sv
tb_tx_iq.sv

// File: Makefile
# Verilator build and run of the TX IQ testbench
# A run passes only if the pass message is found in the log

VERILATOR ?= verilator
TOP       ?= tb_tx_iq
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS"

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

test: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "Test failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
